/* flist.f */
mem_types_pkg.sv
mem_map_pkg.sv
dp_ram.sv
bank_decoder.sv
seg_ram_bank.sv
memory.sv
tb_clock_gen.sv
memory_checker.sv
memory_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module memory_tb -f flist.f -o memory_tb_sim

# Assertion failures are counted by the testbench instead of stopping the run
./obj_dir/memory_tb_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

/* memory_tb.sv */
module memory_tb;

  localparam int MAX_CYCLES = 6000;
  localparam int N_RAND = 16;
  localparam int P_HOST = 0;
  localparam int P_CTL = 1;
  localparam int P_FILTER = 2;
  localparam int P_DUTY = 3;
  localparam int P_MOD = 4;
  localparam int P_STM = 5;

  logic                     bus_clk;
  logic                     reset;
  mem_types_pkg::host_req_t host;
  mem_types_pkg::word_t     host_dout;
  mem_types_pkg::ctl_port_t ctl;
  mem_types_pkg::word_t     ctl_dout;
  logic [6:0]               filter_idx;
  mem_types_pkg::word_t     filter_dout;
  logic [10:0]              duty_idx;
  mem_types_pkg::word_t     duty_dout;
  mem_types_pkg::seg_rd_t   mod_rd;
  mem_types_pkg::word_t     mod_dout;
  mem_types_pkg::seg_rd_t   stm_rd;
  mem_types_pkg::word_t     stm_dout;

  // Expected bank contents and page state
  mem_types_pkg::word_t     ctl_shadow [256];
  mem_types_pkg::word_t     filter_shadow [128];
  mem_types_pkg::word_t     duty_shadow [2048];
  mem_types_pkg::word_t     mod_shadow [2][1024];
  mem_types_pkg::word_t     stm_shadow [2][1024];
  mem_types_pkg::wr_pages_t pages_m;

  logic [31:0] rng;
  int          cycles = 0;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;

  tb_clock_gen clock_gen_i (
    .bus_clk(bus_clk),
    .reset  (reset)
  );

  memory dut_i (
    .bus_clk    (bus_clk),
    .reset      (reset),
    .host       (host),
    .host_dout  (host_dout),
    .ctl        (ctl),
    .ctl_dout   (ctl_dout),
    .filter_idx (filter_idx),
    .filter_dout(filter_dout),
    .duty_idx   (duty_idx),
    .duty_dout  (duty_dout),
    .mod_rd     (mod_rd),
    .mod_dout   (mod_dout),
    .stm_rd     (stm_rd),
    .stm_dout   (stm_dout)
  );

  bind bank_decoder memory_checker checker_i (
    .bus_clk  (bus_clk),
    .reset    (reset),
    .host     (host),
    .ctl_en   (ctl_en),
    .filter_en(filter_en),
    .duty_en  (duty_en),
    .mod_en   (mod_en),
    .stm_en   (stm_en),
    .pages    (pages)
  );

  always @(posedge bus_clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles before the tests finished", cycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Swapped halves keep the weak low LCG bits out of addresses
  task automatic draw(output logic [31:0] v);
    rng = lcg_next(rng);
    v = {rng[15:0], rng[31:16]};
  endtask

  task automatic step();
    @(posedge bus_clk);
    #5;
  endtask

  task automatic update_pages(input mem_types_pkg::host_addr_t addr,
                              input mem_types_pkg::word_t data);
    case (addr)
      mem_map_pkg::ADDR_MOD_WR_SEGMENT: pages_m.mod_segment = data[0];
      mem_map_pkg::ADDR_STM_WR_SEGMENT: pages_m.stm_segment = data[0];
      mem_map_pkg::ADDR_STM_WR_PAGE: pages_m.stm_page = data[3:0];
      mem_map_pkg::ADDR_DUTY_WR_PAGE: pages_m.duty_page = data[0];
      default: begin
      end
    endcase
  endtask

  // Write held for hold edges, then one idle cycle
  task automatic host_write(input mem_types_pkg::bank_sel_t sel,
                            input mem_types_pkg::host_addr_t addr,
                            input mem_types_pkg::word_t data, input int hold);
    host.en = 1'b1;
    host.we = 1'b1;
    host.select = sel;
    host.addr = addr;
    host.data = data;
    repeat (hold) step();
    host.en = 1'b0;
    host.we = 1'b0;
    step();
    case (sel)
      mem_map_pkg::SEL_CONTROLLER: begin
        if (addr[13:8] == mem_map_pkg::SUB_MAIN) begin
          ctl_shadow[addr[7:0]] = data;
          if (hold >= 3) begin
            update_pages(addr, data);
          end
        end else if (addr[13:8] == mem_map_pkg::SUB_FILTER) begin
          filter_shadow[addr[6:0]] = data;
        end
      end
      mem_map_pkg::SEL_DUTY_TABLE: duty_shadow[{pages_m.duty_page, addr[9:0]}] = data;
      mem_map_pkg::SEL_MOD: mod_shadow[pages_m.mod_segment][addr[9:0]] = data;
      default: stm_shadow[pages_m.stm_segment][{pages_m.stm_page, addr[5:0]}] = data;
    endcase
  endtask

  task automatic ctl_write(input logic [7:0] addr, input mem_types_pkg::word_t data);
    ctl.we = 1'b1;
    ctl.addr = addr;
    ctl.din = data;
    step();
    ctl.we = 1'b0;
    ctl_shadow[addr] = data;
  endtask

  // Address set, one edge, then the data is expected on the output
  task automatic read_port(input int port, input logic seg, input logic [15:0] idx,
                           output mem_types_pkg::word_t v);
    case (port)
      P_HOST: begin
        host.en = 1'b1;
        host.we = 1'b0;
        host.select = mem_map_pkg::SEL_CONTROLLER;
        host.addr = {6'h00, idx[7:0]};
      end
      P_CTL: ctl.addr = idx[7:0];
      P_FILTER: filter_idx = idx[6:0];
      P_DUTY: duty_idx = idx[10:0];
      P_MOD: mod_rd = '{segment: seg, idx: idx};
      default: stm_rd = '{segment: seg, idx: idx};
    endcase
    step();
    host.en = 1'b0;
    case (port)
      P_HOST: v = host_dout;
      P_CTL: v = ctl_dout;
      P_FILTER: v = filter_dout;
      P_DUTY: v = duty_dout;
      P_MOD: v = mod_dout;
      default: v = stm_dout;
    endcase
  endtask

  task automatic expect_read(input int port, input logic seg, input logic [15:0] idx,
                             input mem_types_pkg::word_t exp);
    mem_types_pkg::word_t act;
    read_port(port, seg, idx, act);
    assert (act === exp) else begin
      $display("mismatch %s: expected %h, actual %h", test_name, exp, act);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: pass", test_name);
    end else begin
      $display("%s: fail with %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  initial begin
    logic [31:0] r;
    logic [9:0]  a;
    logic [9:0]  addrs [8];

    host = '0;
    ctl = '0;
    filter_idx = '0;
    duty_idx = '0;
    mod_rd = '0;
    stm_rd = '0;
    pages_m = '0;
    rng = 32'h0c53aac7;
    tests_run = 0;
    tests_failed = 0;
    while (reset !== 1'b0) begin
      step();
    end

    begin_test("ctl_host_consumer");
    for (int i = 0; i < N_RAND; i++) begin
      draw(r);
      host_write(mem_map_pkg::SEL_CONTROLLER, {6'h00, r[7:0]}, r[31:16], 1);
      expect_read(P_CTL, 1'b0, {8'h00, r[7:0]}, ctl_shadow[r[7:0]]);
    end
    for (int i = 0; i < N_RAND; i++) begin
      draw(r);
      ctl_write(r[7:0], r[31:16]);
      expect_read(P_HOST, 1'b0, {8'h00, r[7:0]}, ctl_shadow[r[7:0]]);
    end
    end_test();

    begin_test("filter_bank");
    for (int i = 0; i < N_RAND; i++) begin
      draw(r);
      host_write(mem_map_pkg::SEL_CONTROLLER, {7'h00, r[6:0]}, r[31:16], 1);
      host_write(mem_map_pkg::SEL_CONTROLLER, {mem_map_pkg::SUB_FILTER, 1'b0, r[6:0]},
                 r[15:0], 1);
      expect_read(P_FILTER, 1'b0, {9'h000, r[6:0]}, filter_shadow[r[6:0]]);
      expect_read(P_CTL, 1'b0, {9'h000, r[6:0]}, ctl_shadow[{1'b0, r[6:0]}]);
    end
    end_test();

    begin_test("mod_segment");
    for (int i = 0; i < 8; i++) begin
      draw(r);
      addrs[i] = r[9:0];
      host_write(mem_map_pkg::SEL_MOD, {4'h0, addrs[i]}, r[31:16], 1);
    end
    host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_MOD_WR_SEGMENT, 16'h0001, 3);
    for (int i = 0; i < 8; i++) begin
      draw(r);
      host_write(mem_map_pkg::SEL_MOD, {4'h0, addrs[i]}, r[31:16], 1);
    end
    for (int i = 0; i < 8; i++) begin
      expect_read(P_MOD, 1'b0, {6'h00, addrs[i]}, mod_shadow[0][addrs[i]]);
      expect_read(P_MOD, 1'b1, {6'h00, addrs[i]}, mod_shadow[1][addrs[i]]);
    end
    end_test();

    begin_test("stm_page_segment");
    for (int k = 0; k < 4; k++) begin
      draw(r);
      host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_STM_WR_SEGMENT, r[15:0], 3);
      draw(r);
      host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_STM_WR_PAGE, r[15:0], 3);
      for (int j = 0; j < 4; j++) begin
        draw(r);
        host_write(mem_map_pkg::SEL_STM, {8'h00, r[5:0]}, r[31:16], 1);
        expect_read(P_STM, pages_m.stm_segment, {6'h00, pages_m.stm_page, r[5:0]},
                    stm_shadow[pages_m.stm_segment][{pages_m.stm_page, r[5:0]}]);
      end
    end
    end_test();

    begin_test("duty_page_toggle");
    for (int i = 0; i < 4; i++) begin
      draw(r);
      a = r[9:0];
      host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_DUTY_WR_PAGE, 16'h0000, 3);
      host_write(mem_map_pkg::SEL_DUTY_TABLE, {4'h0, a}, r[31:16], 1);
      host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_DUTY_WR_PAGE, 16'h0001, 3);
      host_write(mem_map_pkg::SEL_DUTY_TABLE, {4'h0, a}, ~r[31:16], 1);
      host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_DUTY_WR_PAGE, 16'h0000, 3);
      expect_read(P_DUTY, 1'b0, {6'h00, a}, duty_shadow[{1'b0, a}]);
      expect_read(P_DUTY, 1'b0, {6'h01, a}, duty_shadow[{1'b1, a}]);
    end
    end_test();

    // Single-cycle page writes must leave the old page in place
    begin_test("short_page_write");
    draw(r);
    a = r[9:0];
    host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_DUTY_WR_PAGE, 16'h0001, 1);
    host_write(mem_map_pkg::SEL_DUTY_TABLE, {4'h0, a}, r[31:16], 1);
    expect_read(P_DUTY, 1'b0, {5'h00, pages_m.duty_page, a},
                duty_shadow[{pages_m.duty_page, a}]);
    draw(r);
    host_write(mem_map_pkg::SEL_CONTROLLER, mem_map_pkg::ADDR_MOD_WR_SEGMENT, 16'h0000, 1);
    host_write(mem_map_pkg::SEL_MOD, {4'h0, addrs[0]}, r[31:16], 1);
    expect_read(P_MOD, 1'b0, {6'h00, addrs[0]}, mod_shadow[0][addrs[0]]);
    expect_read(P_MOD, 1'b1, {6'h00, addrs[0]}, mod_shadow[1][addrs[0]]);
    end_test();

    $display("%0d tests run, %0d failed, %0d assertion failures", tests_run, tests_failed,
             dut_i.bank_decoder_i.checker_i.fail_count);
    if (tests_failed == 0 && dut_i.bank_decoder_i.checker_i.fail_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* memory_checker.sv */
module memory_checker (
  input logic                     bus_clk,
  input logic                     reset,
  input mem_types_pkg::host_req_t host,
  input logic                     ctl_en,
  input logic                     filter_en,
  input logic                     duty_en,
  input logic                     mod_en,
  input logic                     stm_en,
  input mem_types_pkg::wr_pages_t pages
);

  int   fail_count = 0;
  logic page_addr;
  logic ctl_wr;

  assign page_addr = (host.addr == mem_map_pkg::ADDR_MOD_WR_SEGMENT) ||
                     (host.addr == mem_map_pkg::ADDR_STM_WR_SEGMENT) ||
                     (host.addr == mem_map_pkg::ADDR_STM_WR_PAGE) ||
                     (host.addr == mem_map_pkg::ADDR_DUTY_WR_PAGE);

  assign ctl_wr = ctl_en && host.we;

  // At most one bank sees the host
  enables_one_hot: assert property (@(posedge bus_clk)
    $onehot0({ctl_en, filter_en, duty_en, mod_en, stm_en}))
  else begin
    $error("more than one bank enable is high");
    fail_count++;
  end

  pages_reset: assert property (@(posedge bus_clk) reset |=> (pages == '0))
  else begin
    $error("page registers not cleared by reset");
    fail_count++;
  end

  // Write rises, stays for two edges, page address on the third edge
  pages_change: assert property (@(posedge bus_clk) disable iff (reset)
    (pages != $past(pages)) |->
    ($past(page_addr) && $past(ctl_wr, 2) && $past(ctl_wr, 3) && !$past(ctl_wr, 4)))
  else begin
    $error("page fields changed without a held page register write");
    fail_count++;
  end

  // A held STM page write loads the low data bits
  stm_page_update: assert property (@(posedge bus_clk) disable iff (reset)
    (($past(host.addr) == mem_map_pkg::ADDR_STM_WR_PAGE) && $past(ctl_wr, 2) &&
     $past(ctl_wr, 3) && !$past(ctl_wr, 4))
    |-> (pages.stm_page == $past(host.data[3:0])))
  else begin
    $error("STM page not loaded by a held page register write");
    fail_count++;
  end

endmodule

/* tb_clock_gen.sv */
module tb_clock_gen #(
  parameter int PERIOD = 40,
  parameter int RESET_CYCLES = 5
) (
  output logic bus_clk,
  output logic reset
);

  initial begin
    bus_clk = 1'b0;
    forever #(PERIOD / 2) bus_clk = ~bus_clk;
  end

  // Released just after an edge, like the rest of the stimulus
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge bus_clk);
    #5;
    reset = 1'b0;
  end

endmodule

/* memory.sv */
module memory #(
  parameter int NUM_SEGMENT = 2,
  parameter int MOD_ADDR_W = 10,
  parameter int STM_ADDR_W = 10,
  parameter int DUTY_ADDR_W = 11
) (
  input  logic                     bus_clk,
  input  logic                     reset,
  // Host bus
  input  mem_types_pkg::host_req_t host,
  output mem_types_pkg::word_t     host_dout,
  // Controller consumer
  input  mem_types_pkg::ctl_port_t ctl,
  output mem_types_pkg::word_t     ctl_dout,
  // Filter consumer
  input  logic [6:0]               filter_idx,
  output mem_types_pkg::word_t     filter_dout,
  // Duty table consumer
  input  logic [DUTY_ADDR_W-1:0]   duty_idx,
  output mem_types_pkg::word_t     duty_dout,
  // Modulation and STM consumers
  input  mem_types_pkg::seg_rd_t   mod_rd,
  output mem_types_pkg::word_t     mod_dout,
  input  mem_types_pkg::seg_rd_t   stm_rd,
  output mem_types_pkg::word_t     stm_dout
);

  localparam int STM_LOW_W = STM_ADDR_W - $bits(mem_types_pkg::stm_page_t);

  logic                     ctl_en;
  logic                     filter_en;
  logic                     duty_en;
  logic                     mod_en;
  logic                     stm_en;
  mem_types_pkg::wr_pages_t pages;
  logic [DUTY_ADDR_W-1:0]   duty_wr_addr;
  logic [STM_ADDR_W-1:0]    stm_wr_addr;

  bank_decoder bank_decoder_i (
    .bus_clk  (bus_clk),
    .reset    (reset),
    .host     (host),
    .ctl_en   (ctl_en),
    .filter_en(filter_en),
    .duty_en  (duty_en),
    .mod_en   (mod_en),
    .stm_en   (stm_en),
    .pages    (pages)
  );

  // Page bits on top of the low host address
  assign duty_wr_addr = {pages.duty_page, host.addr[DUTY_ADDR_W-2:0]};
  assign stm_wr_addr = {pages.stm_page, host.addr[STM_LOW_W-1:0]};

  // Only bank with a host read path
  dp_ram #(
    .ADDR_W(8)
  ) ctl_ram_i (
    .bus_clk(bus_clk),
    .a_en   (ctl_en),
    .a_we   (host.we),
    .a_addr (host.addr[7:0]),
    .a_din  (host.data),
    .a_dout (host_dout),
    .b_we   (ctl.we),
    .b_addr (ctl.addr),
    .b_din  (ctl.din),
    .b_dout (ctl_dout)
  );

  dp_ram #(
    .ADDR_W(7)
  ) filter_ram_i (
    .bus_clk(bus_clk),
    .a_en   (filter_en),
    .a_we   (host.we),
    .a_addr (host.addr[6:0]),
    .a_din  (host.data),
    .a_dout (),
    .b_we   (1'b0),
    .b_addr (filter_idx),
    .b_din  ('0),
    .b_dout (filter_dout)
  );

  dp_ram #(
    .ADDR_W(DUTY_ADDR_W)
  ) duty_ram_i (
    .bus_clk(bus_clk),
    .a_en   (duty_en),
    .a_we   (host.we),
    .a_addr (duty_wr_addr),
    .a_din  (host.data),
    .a_dout (),
    .b_we   (1'b0),
    .b_addr (duty_idx),
    .b_din  ('0),
    .b_dout (duty_dout)
  );

  seg_ram_bank #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .ADDR_W     (MOD_ADDR_W)
  ) mod_bank_i (
    .bus_clk   (bus_clk),
    .wr_en     (mod_en),
    .we        (host.we),
    .wr_segment(pages.mod_segment),
    .wr_addr   (host.addr[MOD_ADDR_W-1:0]),
    .din       (host.data),
    .rd        (mod_rd),
    .dout      (mod_dout)
  );

  seg_ram_bank #(
    .NUM_SEGMENT(NUM_SEGMENT),
    .ADDR_W     (STM_ADDR_W)
  ) stm_bank_i (
    .bus_clk   (bus_clk),
    .wr_en     (stm_en),
    .we        (host.we),
    .wr_segment(pages.stm_segment),
    .wr_addr   (stm_wr_addr),
    .din       (host.data),
    .rd        (stm_rd),
    .dout      (stm_dout)
  );

endmodule

/* seg_ram_bank.sv */
module seg_ram_bank #(
  parameter int NUM_SEGMENT = 2,
  parameter int ADDR_W = 10,
  localparam int SEG_W = (NUM_SEGMENT > 1) ? $clog2(NUM_SEGMENT) : 1
) (
  input  logic                   bus_clk,
  input  logic                   wr_en,
  input  logic                   we,
  input  logic [SEG_W-1:0]       wr_segment,
  input  logic [ADDR_W-1:0]      wr_addr,
  input  mem_types_pkg::word_t   din,
  input  mem_types_pkg::seg_rd_t rd,
  output mem_types_pkg::word_t   dout
);

  logic [NUM_SEGMENT-1:0] seg_en;
  mem_types_pkg::word_t   seg_dout [NUM_SEGMENT];
  logic [SEG_W-1:0]       rd_seg_q;

  for (genvar i = 0; i < NUM_SEGMENT; i++) begin : gen_seg
    // Host enable reaches the selected segment only
    assign seg_en[i] = wr_en && (wr_segment == SEG_W'(i));

    dp_ram #(
      .ADDR_W(ADDR_W)
    ) seg_ram_i (
      .bus_clk(bus_clk),
      .a_en   (seg_en[i]),
      .a_we   (we),
      .a_addr (wr_addr),
      .a_din  (din),
      .a_dout (),
      .b_we   (1'b0),
      .b_addr (rd.idx[ADDR_W-1:0]),
      .b_din  ('0),
      .b_dout (seg_dout[i])
    );
  end

  // Segment delayed to line up with the RAM read latency
  always_ff @(posedge bus_clk) begin
    rd_seg_q <= SEG_W'(rd.segment);
  end

  assign dout = seg_dout[rd_seg_q];

endmodule

/* bank_decoder.sv */
module bank_decoder (
  input  logic                     bus_clk,
  input  logic                     reset,
  input  mem_types_pkg::host_req_t host,
  output logic                     ctl_en,
  output logic                     filter_en,
  output logic                     duty_en,
  output logic                     mod_en,
  output logic                     stm_en,
  output mem_types_pkg::wr_pages_t pages
);

  mem_types_pkg::sub_sel_t sub_sel;
  logic                    ctl_sel;
  logic                    ctl_wr;
  logic [2:0]              wr_hist;
  logic                    page_wr;

  assign sub_sel = host.addr[13:8];

  // Host access aimed at the controller select
  assign ctl_sel = host.en && (host.select == mem_map_pkg::SEL_CONTROLLER);

  // One-hot bank enables
  assign ctl_en = ctl_sel && (sub_sel == mem_map_pkg::SUB_MAIN);
  assign filter_en = ctl_sel && (sub_sel == mem_map_pkg::SUB_FILTER);
  assign duty_en = host.en && (host.select == mem_map_pkg::SEL_DUTY_TABLE);
  assign mod_en = host.en && (host.select == mem_map_pkg::SEL_MOD);
  assign stm_en = host.en && (host.select == mem_map_pkg::SEL_STM);

  assign ctl_wr = ctl_en && host.we;

  // Oldest sample in bit 2
  // 3'b011 means a controller write held over two edges
  assign page_wr = (wr_hist == 3'b011);

  always_ff @(posedge bus_clk) begin
    if (reset) begin
      wr_hist <= '0;
    end else begin
      wr_hist <= {wr_hist[1:0], ctl_wr};
    end
  end

  // Address and data are taken as they stand on the third edge
  always_ff @(posedge bus_clk) begin
    if (reset) begin
      pages <= '0;
    end else if (page_wr) begin
      case (host.addr)
        mem_map_pkg::ADDR_MOD_WR_SEGMENT: begin
          pages.mod_segment <= host.data[0];
        end
        mem_map_pkg::ADDR_STM_WR_SEGMENT: begin
          pages.stm_segment <= host.data[0];
        end
        mem_map_pkg::ADDR_STM_WR_PAGE: begin
          pages.stm_page <= host.data[3:0];
        end
        mem_map_pkg::ADDR_DUTY_WR_PAGE: begin
          pages.duty_page <= host.data[0];
        end
        default: begin
          // Ordinary controller word, nothing to update
        end
      endcase
    end
  end

endmodule

/* dp_ram.sv */
module dp_ram #(
  parameter int ADDR_W = 8
) (
  input  logic                 bus_clk,
  // Port A, host side
  input  logic                 a_en,
  input  logic                 a_we,
  input  logic [ADDR_W-1:0]    a_addr,
  input  mem_types_pkg::word_t a_din,
  output mem_types_pkg::word_t a_dout,
  // Port B, consumer side
  input  logic                 b_we,
  input  logic [ADDR_W-1:0]    b_addr,
  input  mem_types_pkg::word_t b_din,
  output mem_types_pkg::word_t b_dout
);

  localparam int DEPTH = 1 << ADDR_W;

  mem_types_pkg::word_t mem [DEPTH];

  // Both ports share one array
  // Reads return the old word when a port writes its own address
  always_ff @(posedge bus_clk) begin
    if (a_en) begin
      if (a_we) begin
        mem[a_addr] <= a_din;
      end
      a_dout <= mem[a_addr];
    end

    if (b_we) begin
      mem[b_addr] <= b_din;
    end
    // Port B has no enable and reads every cycle
    b_dout <= mem[b_addr];
  end

endmodule

/* mem_map_pkg.sv */
package mem_map_pkg;

  // Bank select codes on host select
  localparam mem_types_pkg::bank_sel_t SEL_CONTROLLER = 2'd0;
  localparam mem_types_pkg::bank_sel_t SEL_MOD = 2'd1;
  localparam mem_types_pkg::bank_sel_t SEL_DUTY_TABLE = 2'd2;
  localparam mem_types_pkg::bank_sel_t SEL_STM = 2'd3;

  // Sub-bank codes inside the controller select
  localparam mem_types_pkg::sub_sel_t SUB_MAIN = 6'h00;
  localparam mem_types_pkg::sub_sel_t SUB_FILTER = 6'h01;

  // Page register addresses, all in the controller main bank
  // so sub-bank bits stay zero
  localparam mem_types_pkg::host_addr_t ADDR_MOD_WR_SEGMENT = 14'h0020;
  localparam mem_types_pkg::host_addr_t ADDR_STM_WR_SEGMENT = 14'h0021;
  localparam mem_types_pkg::host_addr_t ADDR_STM_WR_PAGE = 14'h0022;
  localparam mem_types_pkg::host_addr_t ADDR_DUTY_WR_PAGE = 14'h0023;

  // Host writes to these addresses still land in the controller RAM
  // The decoder only snoops them

endpackage

/* mem_types_pkg.sv */
package mem_types_pkg;

  // Host word address below the bank select field
  typedef logic [13:0] host_addr_t;

  // All banks carry 16-bit words on every port
  typedef logic [15:0] word_t;

  typedef logic [1:0] bank_sel_t;

  // Controller sub-bank code, host address bits 13 to 8
  typedef logic [5:0] sub_sel_t;

  // STM write page, upper bits of the STM RAM address
  typedef logic [3:0] stm_page_t;

  // One host access per cycle, no handshake
  typedef struct packed {
    logic       en;
    logic       we;
    bank_sel_t  select;
    host_addr_t addr;
    word_t      data;
  } host_req_t;

  // Controller consumer port into the controller RAM
  typedef struct packed {
    logic       we;
    logic [7:0] addr;
    word_t      din;
  } ctl_port_t;

  // Read request for a segmented bank
  typedef struct packed {
    logic        segment;
    logic [15:0] idx;
  } seg_rd_t;

  // Page and segment registers that steer host writes
  typedef struct packed {
    logic      mod_segment;
    logic      stm_segment;
    stm_page_t stm_page;
    logic      duty_page;
  } wr_pages_t;

endpackage
